/* noc_pkg.sv */
//--------------------------------------------------
// flit widths, the header/data view of the payload and
// small index helpers shared by the router input port
// modules take it with a wildcard import in the header
//--------------------------------------------------
package noc_pkg;

    localparam int FPAY    = 32;                 // payload bits per flit
    localparam int CLASS_W = 2;                  // message class field
    localparam int DSTP_W  = 4;                  // destination port field
    localparam int FLIT_W  = FPAY + 2;           // hdr and tail flags on top
    localparam int HDR_BIT = FLIT_W - 1;         // header flag position
    localparam int HREST_W = FPAY - CLASS_W - DSTP_W;

    // one payload word, read as header fields or as plain data
    // depending on the header flag that travels with it
    typedef union packed {
        struct packed {
            logic [CLASS_W-1:0] cls;             // class sits in the top bits
            logic [DSTP_W-1:0]  dstp;            // port for the routing stage
            logic [HREST_W-1:0] rest;            // addresses, not used here
        } hdr;
        logic [FPAY-1:0] data;                   // body and tail flits
    } flit_payload_u;

    // index width, never below one bit
    function automatic int clog2_min1(input int n);
        return (n <= 2) ? 1 : $clog2(n);
    endfunction

    // one-hot vc select to binary index
    // lowest set bit wins, all zero gives 0
    function automatic int vc_onehot_to_bin(input logic [31:0] onehot);
        int idx;
        idx = 0;
        for (int i = 31; i >= 0; i--) begin
            if (onehot[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

endpackage

/* hdr_flit_decode.sv */
//--------------------------------------------------
// header field decoder for the flit entering a head
// register; purely combinational, the caller decides
// whether the flit really is a header
//--------------------------------------------------
`timescale 1ns/10ps

module hdr_flit_decode
    import noc_pkg::*;
(
    input  logic [FLIT_W-1:0]  flit_i,     // flags on top, payload below
    output logic [CLASS_W-1:0] class_o,    // message class
    output logic [DSTP_W-1:0]  dstp_o      // destination port
);

    flit_payload_u pay;                    // payload seen through the hdr view

    assign pay = flit_i[FPAY-1:0];         // flags dropped

    // class and port come straight out of the header layout
    assign class_o = pay.hdr.cls;
    assign dstp_o  = pay.hdr.dstp;         // routing stage qualifies it

endmodule

/* vc_flit_store.sv */
//--------------------------------------------------
// shared circular flit store, B slots per vc, one
// region per vc with its own pointers and count;
// registered read data, one cycle after the strobe
//--------------------------------------------------
`timescale 1ns/10ps

module vc_flit_store
    import noc_pkg::*;
#(
    parameter int V = 4,                       // virtual channels
    parameter int B = 4                        // slots per vc
)(
    input  logic              clk,
    input  logic              reset,
    input  logic [FLIT_W-1:0] din_i,
    input  logic [V-1:0]      wr_vc_i,         // one-hot
    input  logic              wr_en_i,
    input  logic [V-1:0]      rd_vc_i,         // one-hot
    input  logic              rd_en_i,
    output logic [FLIT_W-1:0] dout_o,          // valid the cycle after rd_en_i
    output logic [V-1:0]      not_empty_o
);

    localparam int VW    = clog2_min1(V);
    localparam int PW    = clog2_min1(B);      // slot pointer
    localparam int CW    = clog2_min1(B + 1);  // occupancy 0..B
    localparam int DEPTH = V * B;
    localparam int AW    = clog2_min1(DEPTH);

    logic [FLIT_W-1:0] mem [DEPTH];            // vc regions back to back
    logic [PW-1:0]     wr_ptr [V];
    logic [PW-1:0]     rd_ptr [V];
    logic [CW-1:0]     count [V];
    logic [V-1:0]      full;
    logic [VW-1:0]     wr_idx;
    logic [VW-1:0]     rd_idx;
    logic [AW-1:0]     wr_addr;
    logic [AW-1:0]     rd_addr;

    assign wr_idx = VW'(vc_onehot_to_bin(32'(wr_vc_i)));
    assign rd_idx = VW'(vc_onehot_to_bin(32'(rd_vc_i)));

    // region base plus slot inside the region
    assign wr_addr = AW'(int'(wr_idx) * B + int'(wr_ptr[wr_idx]));
    assign rd_addr = AW'(int'(rd_idx) * B + int'(rd_ptr[rd_idx]));

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr] <= din_i;
        end
        if (rd_en_i) begin
            dout_o <= mem[rd_addr];            // old word if same slot written
        end
    end

    for (genvar v = 0; v < V; v++) begin : g_vc
        logic wr_here;
        logic rd_here;

        assign wr_here = wr_en_i & wr_vc_i[v];
        assign rd_here = rd_en_i & rd_vc_i[v];

        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end else begin
                if (wr_here) begin
                    wr_ptr[v] <= (wr_ptr[v] == PW'(B - 1)) ? '0 : wr_ptr[v] + PW'(1);
                end
                if (rd_here) begin
                    rd_ptr[v] <= (rd_ptr[v] == PW'(B - 1)) ? '0 : rd_ptr[v] + PW'(1);
                end
                if (wr_here && !rd_here) begin
                    count[v] <= count[v] + CW'(1);
                end else if (rd_here && !wr_here) begin
                    count[v] <= count[v] - CW'(1);
                end
            end
        end

        assign not_empty_o[v] = (count[v] != '0);
        assign full[v]        = (count[v] == CW'(B));
    end

    // a full region only takes a flit while its oldest one leaves
    a_no_wr_full: assert property (@(posedge clk) disable iff (reset)
        (wr_en_i && |(wr_vc_i & full)) |-> (rd_en_i && rd_vc_i == wr_vc_i))
        else $error("ERR store write to full region, wr_vc %h", wr_vc_i);

    // head control must never ask for a flit that is not there
    a_no_rd_empty: assert property (@(posedge clk) disable iff (reset)
        rd_en_i |-> |(rd_vc_i & not_empty_o))
        else $error("ERR store read from empty region, rd_vc %h", rd_vc_i);

endmodule

/* vc_head_regs.sv */
//--------------------------------------------------
// per-vc head registers in front of the flit store:
// bypass or store decision on write, refill after a
// read, class capture for headers and the output mux
//--------------------------------------------------
`timescale 1ns/10ps

module vc_head_regs
    import noc_pkg::*;
#(
    parameter int V = 4,                           // virtual channels
    parameter int B = 4                            // store slots per vc
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [FLIT_W-1:0]    flit_i,
    input  logic [V-1:0]         wr_vc_i,
    input  logic                 wr_en_i,
    input  logic [V-1:0]         rd_vc_i,
    input  logic                 rd_en_i,
    input  logic [FLIT_W-1:0]    store_dout_i,     // refill data
    input  logic [V-1:0]         store_not_empty_i,
    input  logic [CLASS_W-1:0]   class_i,          // decoded from dec_flit_o
    output logic [FLIT_W-1:0]    dec_flit_o,
    output logic                 store_wr_en_o,
    output logic                 store_rd_en_o,
    output logic [FLIT_W+V-1:0]  dout_o,           // flags, one-hot vc, payload
    output logic [V-1:0]         vc_not_empty_o,
    output logic [V*CLASS_W-1:0] class_all_o
);

    localparam int VW = clog2_min1(V);
    localparam int OW = clog2_min1(B + 2);         // vc occupancy 0..B+1

    logic [FLIT_W-1:0]  head_q [V];                // oldest flit of each vc
    logic [CLASS_W-1:0] cls_q [V];
    logic [V-1:0]       valid_q;
    logic [OW-1:0]      occ_q [V];                 // head plus store, per vc
    logic [V-1:0]       wr_sel;
    logic [V-1:0]       rd_sel;
    logic [V-1:0]       load_now;                  // write into an empty head
    logic [V-1:0]       swap_now;                  // write and read, store empty
    logic [V-1:0]       refill_now;                // read, flit waiting in store
    logic [V-1:0]       swap_q;
    logic [V-1:0]       refill_q;
    logic [V-1:0]       dly_load;
    logic [FLIT_W-1:0]  swap_flit_q;               // new head held for one cycle
    logic [VW-1:0]      rd_idx;
    logic [VW-1:0]      rd_idx_q;
    logic [FLIT_W-1:0]  out_head;
    logic [V-1:0]       out_vc;
    flit_payload_u      in_pay;                    // incoming flit, hdr view

    assign wr_sel = wr_en_i ? wr_vc_i : '0;
    assign rd_sel = rd_en_i ? rd_vc_i : '0;
    assign rd_idx = VW'(vc_onehot_to_bin(32'(rd_vc_i)));

    assign load_now   = wr_sel & ~valid_q;
    assign swap_now   = wr_sel & valid_q & rd_sel & ~store_not_empty_i;
    assign refill_now = rd_sel & store_not_empty_i;

    assign store_wr_en_o = wr_en_i & ~|(load_now | swap_now);  // bypass cases kept out
    assign store_rd_en_o = |refill_now;

    // both delayed loads come from the single read of the last cycle,
    // so at most one vc loads through this path per cycle
    assign dly_load   = swap_q | refill_q;
    assign dec_flit_o = (|swap_q) ? swap_flit_q : store_dout_i;
    assign in_pay     = flit_i[FPAY-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            swap_q   <= '0;
            refill_q <= '0;
            rd_idx_q <= '0;
        end else begin
            swap_q   <= swap_now;
            refill_q <= refill_now;
            if (rd_en_i) begin
                rd_idx_q <= rd_idx;                // picks dout next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|swap_now) begin
            swap_flit_q <= flit_i;
        end
    end

    for (genvar v = 0; v < V; v++) begin : g_vc
        always_ff @(posedge clk) begin
            if (load_now[v]) begin
                head_q[v] <= flit_i;               // empty vc, straight in
            end else if (dly_load[v]) begin
                head_q[v] <= dec_flit_o;           // swap or refill
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q[v] <= 1'b0;
                cls_q[v]   <= '0;
            end else begin
                if (load_now[v]) begin
                    valid_q[v] <= 1'b1;
                end else if (rd_sel[v] && !store_not_empty_i[v] && !swap_now[v]) begin
                    valid_q[v] <= 1'b0;            // last flit gone
                end
                if (load_now[v] && flit_i[HDR_BIT]) begin
                    cls_q[v] <= in_pay.hdr.cls;
                end else if (dly_load[v] && dec_flit_o[HDR_BIT]) begin
                    cls_q[v] <= class_i;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                occ_q[v] <= '0;
            end else if (wr_sel[v] && !rd_sel[v]) begin
                occ_q[v] <= occ_q[v] + OW'(1);
            end else if (rd_sel[v] && !wr_sel[v]) begin
                occ_q[v] <= occ_q[v] - OW'(1);
            end
        end

        assign class_all_o[v*CLASS_W +: CLASS_W] = cls_q[v];

        // head plus store never exceed B+1 flits
        a_vc_cap: assert property (@(posedge clk) disable iff (reset)
            (wr_sel[v] && !rd_sel[v]) |-> (occ_q[v] <= OW'(B)))
            else $error("ERR vc %0d overflow, occ %h", v, occ_q[v]);
    end

    assign vc_not_empty_o = valid_q;

    // popped flit stays in its head until the refill edge
    assign out_head = head_q[rd_idx_q];
    assign out_vc   = V'(1) << rd_idx_q;
    assign dout_o   = {out_head[FLIT_W-1:FPAY], out_vc, out_head[FPAY-1:0]};

    a_rd_valid: assert property (@(posedge clk) disable iff (reset)
        rd_en_i |-> |(rd_vc_i & valid_q))
        else $error("ERR read of empty vc, rd_vc %h valid %h", rd_vc_i, valid_q);

    // refill takes a cycle, same vc may not be read back to back
    a_rd_spacing: assert property (@(posedge clk) disable iff (reset)
        rd_en_i |=> !(rd_en_i && rd_vc_i == $past(rd_vc_i)))
        else $error("ERR back to back read of vc %h", rd_vc_i);

    a_sel_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(wr_vc_i) && $onehot0(rd_vc_i))
        else $error("ERR select not one-hot, wr %h rd %h", wr_vc_i, rd_vc_i);

endmodule

/* router_input_port.sv */
//--------------------------------------------------
// input port of a virtual-channel router: shared flit
// store, per-vc head registers and header decoder;
// V and B are set here and passed down
//--------------------------------------------------
`timescale 1ns/10ps

module router_input_port
    import noc_pkg::*;
#(
    parameter int V = 4,                           // virtual channels
    parameter int B = 4                            // store slots per vc
)(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [FLIT_W-1:0]    flit_i,           // flags in the top two bits
    input  logic [V-1:0]         wr_vc_i,          // one-hot
    input  logic                 wr_en_i,
    input  logic [V-1:0]         rd_vc_i,          // one-hot
    input  logic                 rd_en_i,
    output logic [FLIT_W+V-1:0]  dout_o,
    output logic [V-1:0]         vc_not_empty_o,
    output logic [V*CLASS_W-1:0] class_all_o
);

    logic [FLIT_W-1:0]  store_dout;
    logic [V-1:0]       store_not_empty;
    logic               store_wr_en;
    logic               store_rd_en;
    logic [FLIT_W-1:0]  dec_flit;                  // flit entering a head
    logic [CLASS_W-1:0] dec_class;

    vc_flit_store #(
        .V (V),
        .B (B)
    ) vc_flit_store_i (
        .clk         (clk),
        .reset       (reset),
        .din_i       (flit_i),
        .wr_vc_i     (wr_vc_i),
        .wr_en_i     (store_wr_en),
        .rd_vc_i     (rd_vc_i),
        .rd_en_i     (store_rd_en),
        .dout_o      (store_dout),
        .not_empty_o (store_not_empty)
    );

    vc_head_regs #(
        .V (V),
        .B (B)
    ) vc_head_regs_i (
        .clk               (clk),
        .reset             (reset),
        .flit_i            (flit_i),
        .wr_vc_i           (wr_vc_i),
        .wr_en_i           (wr_en_i),
        .rd_vc_i           (rd_vc_i),
        .rd_en_i           (rd_en_i),
        .store_dout_i      (store_dout),
        .store_not_empty_i (store_not_empty),
        .class_i           (dec_class),
        .dec_flit_o        (dec_flit),
        .store_wr_en_o     (store_wr_en),
        .store_rd_en_o     (store_rd_en),
        .dout_o            (dout_o),
        .vc_not_empty_o    (vc_not_empty_o),
        .class_all_o       (class_all_o)
    );

    hdr_flit_decode hdr_flit_decode_i (
        .flit_i  (dec_flit),
        .class_o (dec_class),
        .dstp_o  ()                                // for the routing stage
    );

endmodule

/* router_input_port_tb.sv */
//--------------------------------------------------
// testbench for the router input port: directed and
// xorshift traffic against per-vc model queues, with
// concurrent assertions comparing the dut outputs
//--------------------------------------------------
`timescale 1ns/10ps

module router_input_port_tb
    import noc_pkg::*;
();

    localparam int V           = 4;                // virtual channels
    localparam int B           = 4;                // store slots per vc
    localparam int RAND_CYCLES = 400;

    logic                 clk;
    logic                 reset;
    logic [FLIT_W-1:0]    flit;
    logic [V-1:0]         wr_vc;
    logic                 wr_en;
    logic [V-1:0]         rd_vc;
    logic                 rd_en;
    logic [FLIT_W+V-1:0]  dout;
    logic [V-1:0]         vc_not_empty;
    logic [V*CLASS_W-1:0] class_all;

    logic [FLIT_W-1:0]    mq [V][$];               // flits per vc, oldest first
    logic [FLIT_W-1:0]    pend_flit [V];           // next head, loads one edge late
    logic [V-1:0]         pend_vld;
    logic [CLASS_W-1:0]   exp_cls [V];
    logic [V*CLASS_W-1:0] exp_cls_all;
    logic [V-1:0]         exp_ne;
    logic [FLIT_W+V-1:0]  exp_dout;
    logic                 chk_dout;                // a read was taken last edge
    logic                 rst_chk;
    logic [31:0]          rng;
    int                   last_rd;                 // vc read in the last cycle, -1 none
    int                   err_cnt;
    int                   err_base;
    int                   test_cnt;
    int                   test_fail;

    router_input_port #(
        .V (V),
        .B (B)
    ) router_input_port_i (
        .clk            (clk),
        .reset          (reset),
        .flit_i         (flit),
        .wr_vc_i        (wr_vc),
        .wr_en_i        (wr_en),
        .rd_vc_i        (rd_vc),
        .rd_en_i        (rd_en),
        .dout_o         (dout),
        .vc_not_empty_o (vc_not_empty),
        .class_all_o    (class_all)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;                        // 40 ns period
        end
    end

    a_dout: assert property (@(posedge clk) disable iff (reset)
        chk_dout |-> (dout == exp_dout))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR dout_o got %h exp %h", $sampled(dout), $sampled(exp_dout));
        end

    a_ne: assert property (@(posedge clk) disable iff (reset)
        vc_not_empty == exp_ne)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR vc_not_empty_o got %h exp %h", $sampled(vc_not_empty),
                     $sampled(exp_ne));
        end

    a_cls: assert property (@(posedge clk) disable iff (reset)
        class_all == exp_cls_all)
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR class_all_o got %h exp %h", $sampled(class_all),
                     $sampled(exp_cls_all));
        end

    // held in reset, both outputs must read zero
    a_rst: assert property (@(posedge clk)
        rst_chk |-> (vc_not_empty == '0 && class_all == '0))
        else begin
            err_cnt = err_cnt + 1;
            $display("ERR reset vc_not_empty_o %h class_all_o %h", $sampled(vc_not_empty),
                     $sampled(class_all));
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [FLIT_W-1:0] make_flit(input logic hdr, input logic tail,
                                                    input logic [FPAY-1:0] pay);
        return {hdr, tail, pay};                   // flags on top
    endfunction

    function automatic logic [FLIT_W-1:0] make_hdr(input logic [CLASS_W-1:0] cls,
                                                   input logic tail);
        logic [FPAY-1:0] pay;
        pay = rand32();
        pay[FPAY-1 -: CLASS_W] = cls;              // class in the top payload bits
        return {1'b1, tail, pay};
    endfunction

    function automatic logic [CLASS_W-1:0] class_of(input logic [FLIT_W-1:0] f);
        return f[FPAY-1 -: CLASS_W];
    endfunction

    function automatic int vc_index(input logic [V-1:0] sel);
        int idx;
        idx = 0;
        for (int i = 0; i < V; i++) begin
            if (sel[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic bit all_empty();
        bit e;
        e = 1'b1;
        for (int i = 0; i < V; i++) begin
            if (mq[i].size() > 0) begin
                e = 1'b0;
            end
        end
        return e;
    endfunction

    // apply the strobes of the cycle that just ended to the model
    task automatic update_model();
        logic [FLIT_W-1:0] popped;
        int r;
        int w;
        bit w_was_empty;
        for (int v = 0; v < V; v++) begin
            if (pend_vld[v] && pend_flit[v][HDR_BIT]) begin
                exp_cls[v] = class_of(pend_flit[v]);  // refill or swap landed
            end
            pend_vld[v] = 1'b0;
        end
        r = vc_index(rd_vc);
        w = vc_index(wr_vc);
        w_was_empty = wr_en && (mq[w].size() == 0);
        chk_dout = rd_en;
        if (rd_en) begin
            popped   = mq[r].pop_front();
            exp_dout = {popped[FLIT_W-1:FPAY], (V'(1) << r), popped[FPAY-1:0]};
        end
        if (wr_en) begin
            mq[w].push_back(flit);
        end
        if (w_was_empty && flit[HDR_BIT]) begin
            exp_cls[w] = class_of(flit);           // straight into an empty head
        end
        if (rd_en && mq[r].size() > 0) begin
            pend_vld[r]  = 1'b1;
            pend_flit[r] = mq[r][0];
        end
        for (int v = 0; v < V; v++) begin
            exp_ne[v] = (mq[v].size() != 0);
            exp_cls_all[v*CLASS_W +: CLASS_W] = exp_cls[v];
        end
    endtask

    // one cycle of stimulus, then the edge and the model update
    task automatic drive(input logic w_en, input int w, input logic [FLIT_W-1:0] f,
                         input logic r_en, input int r);
        wr_en   = w_en;
        wr_vc   = w_en ? (V'(1) << w) : '0;
        flit    = f;
        rd_en   = r_en;
        rd_vc   = r_en ? (V'(1) << r) : '0;
        last_rd = r_en ? r : -1;
        @(posedge clk);
        #2;
        update_model();
    endtask

    task automatic idle();
        drive(1'b0, 0, '0, 1'b0, 0);
    endtask

    task automatic wait_ne(input int v);
        int n;
        n = 0;
        while (!vc_not_empty[v] && n < 20) begin
            idle();
            n++;
        end
        if (!vc_not_empty[v]) begin
            $display("timeout: vc %0d never showed a flit at its head", v);
            $display("Simulation failed");
            $finish;
        end
    endtask

    // read out every vc, keeping reads of one vc a cycle apart
    task automatic drain_all(input int max_cycles);
        int n;
        int c;
        int pick;
        n = 0;
        while (!all_empty() && n < max_cycles) begin
            pick = -1;
            for (int i = 0; i < V; i++) begin
                c = (i + n) % V;                   // rotate the start vc
                if (pick < 0 && mq[c].size() > 0 && c != last_rd) begin
                    pick = c;
                end
            end
            if (pick >= 0) begin
                drive(1'b0, 0, '0, 1'b1, pick);
            end else begin
                idle();
            end
            n++;
        end
        if (!all_empty()) begin
            $display("timeout: vcs still hold flits after %0d drain cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic end_test(input string name);
        idle();
        idle();                                    // let the last dout check fire
        test_cnt++;
        if (err_cnt != err_base) begin
            test_fail++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_base);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
        err_base = err_cnt;
    endtask

    initial begin
        logic [FLIT_W-1:0] f;
        logic [31:0]       t;
        int                w;
        int                r;
        logic              do_w;
        logic              do_r;
        reset    = 1'b1;
        flit     = '0;
        wr_vc    = '0;
        wr_en    = 1'b0;
        rd_vc    = '0;
        rd_en    = 1'b0;
        rng      = 32'h5bd3_2bfd;
        last_rd  = -1;
        err_cnt  = 0;
        err_base = 0;
        test_cnt = 0;
        test_fail = 0;
        chk_dout = 1'b0;
        rst_chk  = 1'b0;
        pend_vld = '0;
        exp_ne   = '0;
        exp_dout = '0;
        exp_cls_all = '0;
        for (int v = 0; v < V; v++) begin
            exp_cls[v] = '0;
        end

        for (int i = 0; i < 8; i++) begin
            idle();
            rst_chk = 1'b1;                        // registers cleared from edge one on
        end
        reset = 1'b0;
        idle();                                    // first cycle out of reset
        rst_chk = 1'b0;
        end_test("reset state");

        f = make_flit(1'b1, 1'b1, rand32());
        drive(1'b1, 1, f, 1'b0, 0);
        wait_ne(1);
        drive(1'b0, 0, '0, 1'b1, 1);
        end_test("bypass");

        for (int i = 0; i <= B; i++) begin
            f = make_flit(i == 0, i == B, rand32());
            drive(1'b1, 2, f, 1'b0, 0);            // head plus a full region
        end
        wait_ne(2);
        drain_all(4 * B + 8);
        end_test("store order");

        drive(1'b1, 0, make_hdr(2'b01, 1'b1), 1'b0, 0);
        wait_ne(0);
        drive(1'b1, 0, make_hdr(2'b10, 1'b1), 1'b1, 0);   // old head out, new in
        idle();
        drain_all(8);
        end_test("write and read, head only");

        for (int n = 0; n < RAND_CYCLES; n++) begin
            r    = int'(rand32() % V);
            do_r = ((rand32() % 8) < 5) && (mq[r].size() > 0) && (r != last_rd);
            w    = int'(rand32() % V);
            do_w = ((rand32() % 8) < 5) &&
                   ((mq[w].size() - ((do_r && r == w) ? 1 : 0)) < B + 1);
            t    = rand32();
            f    = make_flit(t[0], t[1], rand32());
            drive(do_w, w, f, do_r, r);
        end
        drain_all(V * (B + 1) * 2 + 8);
        end_test("random traffic");

        drive(1'b1, 3, make_hdr(2'b10, 1'b0), 1'b0, 0);
        for (int i = 0; i < 3; i++) begin
            drive(1'b1, 3, make_flit(1'b0, i == 2, rand32()), 1'b0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            if (i == 0) begin
                f = make_hdr(2'b01, 1'b0);
            end else if (i == 3) begin
                f = make_hdr(2'b11, 1'b1);         // single-flit packet
            end else begin
                f = make_flit(1'b0, i == 2, rand32());
            end
            drive(1'b1, 3, f, 1'b1, 3);            // next packet queues behind the read
            idle();
        end
        drain_all(4 * B + 8);
        end_test("class capture");

        $display("tests %0d, with errors %0d, assertion errors %0d",
                 test_cnt, test_fail, err_cnt);
        if (err_cnt == 0 && test_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* files.f */
noc_pkg.sv
hdr_flit_decode.sv
vc_flit_store.sv
vc_head_regs.sv
router_input_port.sv
router_input_port_tb.sv
